//--- design/rv_ex_pkg.sv
// RV execute stage package with shared types, decode patterns and control structs
package rv_ex_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Basic widths
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [31:0] instr_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [11:0] csr_addr_t;

  // func7, func3 and opcode[6:2] side by side
  typedef logic [14:0] dec_pat_t;

  // Major opcodes, bits 6:2 of the instruction
  localparam logic [4:0] OPC_LUI     = 5'b01101;
  localparam logic [4:0] OPC_AUIPC   = 5'b00101;
  localparam logic [4:0] OPC_JAL     = 5'b11011;
  localparam logic [4:0] OPC_JALR    = 5'b11001;
  localparam logic [4:0] OPC_OPIMM   = 5'b00100;
  localparam logic [4:0] OPC_OP      = 5'b01100;
  localparam logic [4:0] OPC_OPIMM32 = 5'b00110;
  localparam logic [4:0] OPC_OP32    = 5'b01110;
  localparam logic [4:0] OPC_SYSTEM  = 5'b11100;

  ////////////////////////////////////////////////////////////////////////////
  // Instruction patterns, ? marks a don't care bit
  ////////////////////////////////////////////////////////////////////////////

  // Upper immediate and jumps
  localparam dec_pat_t LUI    = {7'b???????, 3'b???, OPC_LUI};
  localparam dec_pat_t AUIPC  = {7'b???????, 3'b???, OPC_AUIPC};
  localparam dec_pat_t JAL    = {7'b???????, 3'b???, OPC_JAL};
  localparam dec_pat_t JALR   = {7'b???????, 3'b000, OPC_JALR};

  // Register-immediate, bit 25 is shamt[5] on RV64
  localparam dec_pat_t ADDI   = {7'b???????, 3'b000, OPC_OPIMM};
  localparam dec_pat_t SLTI   = {7'b???????, 3'b010, OPC_OPIMM};
  localparam dec_pat_t SLTIU  = {7'b???????, 3'b011, OPC_OPIMM};
  localparam dec_pat_t XORI   = {7'b???????, 3'b100, OPC_OPIMM};
  localparam dec_pat_t ORI    = {7'b???????, 3'b110, OPC_OPIMM};
  localparam dec_pat_t ANDI   = {7'b???????, 3'b111, OPC_OPIMM};
  localparam dec_pat_t SLLI   = {7'b000000?, 3'b001, OPC_OPIMM};
  localparam dec_pat_t SRLI   = {7'b000000?, 3'b101, OPC_OPIMM};
  localparam dec_pat_t SRAI   = {7'b010000?, 3'b101, OPC_OPIMM};

  // Register-register
  localparam dec_pat_t ADD    = {7'b0000000, 3'b000, OPC_OP};
  localparam dec_pat_t SUB    = {7'b0100000, 3'b000, OPC_OP};
  localparam dec_pat_t SLL    = {7'b0000000, 3'b001, OPC_OP};
  localparam dec_pat_t SLT    = {7'b0000000, 3'b010, OPC_OP};
  localparam dec_pat_t SLTU   = {7'b0000000, 3'b011, OPC_OP};
  localparam dec_pat_t XOR    = {7'b0000000, 3'b100, OPC_OP};
  localparam dec_pat_t SRL    = {7'b0000000, 3'b101, OPC_OP};
  localparam dec_pat_t SRA    = {7'b0100000, 3'b101, OPC_OP};
  localparam dec_pat_t OR     = {7'b0000000, 3'b110, OPC_OP};
  localparam dec_pat_t AND    = {7'b0000000, 3'b111, OPC_OP};

  // RV64 word forms
  localparam dec_pat_t ADDIW  = {7'b???????, 3'b000, OPC_OPIMM32};
  localparam dec_pat_t SLLIW  = {7'b0000000, 3'b001, OPC_OPIMM32};
  localparam dec_pat_t SRLIW  = {7'b0000000, 3'b101, OPC_OPIMM32};
  localparam dec_pat_t SRAIW  = {7'b0100000, 3'b101, OPC_OPIMM32};
  localparam dec_pat_t ADDW   = {7'b0000000, 3'b000, OPC_OP32};
  localparam dec_pat_t SUBW   = {7'b0100000, 3'b000, OPC_OP32};
  localparam dec_pat_t SLLW   = {7'b0000000, 3'b001, OPC_OP32};
  localparam dec_pat_t SRLW   = {7'b0000000, 3'b101, OPC_OP32};
  localparam dec_pat_t SRAW   = {7'b0100000, 3'b101, OPC_OP32};

  // CSR access
  localparam dec_pat_t CSRRW  = {7'b???????, 3'b001, OPC_SYSTEM};
  localparam dec_pat_t CSRRS  = {7'b???????, 3'b010, OPC_SYSTEM};
  localparam dec_pat_t CSRRC  = {7'b???????, 3'b011, OPC_SYSTEM};
  localparam dec_pat_t CSRRWI = {7'b???????, 3'b101, OPC_SYSTEM};
  localparam dec_pat_t CSRRSI = {7'b???????, 3'b110, OPC_SYSTEM};
  localparam dec_pat_t CSRRCI = {7'b???????, 3'b111, OPC_SYSTEM};

  // Machine CSR addresses
  localparam csr_addr_t CSR_MSCRATCH = 12'h340;
  localparam csr_addr_t CSR_MEPC     = 12'h341;
  localparam csr_addr_t CSR_MCAUSE   = 12'h342;
  localparam csr_addr_t CSR_MTVEC    = 12'h305;

  ////////////////////////////////////////////////////////////////////////////
  // Control bundles
  ////////////////////////////////////////////////////////////////////////////

  // Instruction entering the ALU
  typedef struct packed {
    logic   bubble;
    instr_t instr;
  } ex_ctl_t;

  // Write-back target
  typedef struct packed {
    logic     valid;
    reg_idx_t rd;
  } wb_ctl_t;

endpackage

//--- design/rv_regfile.sv
// Integer register file with x0 tied to zero, two read ports and one write port
`timescale 1ns/100ps

module rv_regfile #(
  parameter int XLEN = 32
) (
  input  logic                clk,
  input  logic                rstn,
  input  rv_ex_pkg::reg_idx_t rs1_idx,
  input  rv_ex_pkg::reg_idx_t rs2_idx,
  output logic [XLEN-1:0]     rs1_val,
  output logic [XLEN-1:0]     rs2_val,
  input  rv_ex_pkg::wb_ctl_t  wb_ctl,
  input  logic [XLEN-1:0]     wb_value
);

  // x0 has no storage
  logic [XLEN-1:0] regs [1:31];

  // Write port
  // rd of zero is dropped here
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_ctl.valid && (wb_ctl.rd != 5'd0)) begin
      regs[wb_ctl.rd] <= wb_value;
    end
  end

  // Read ports, combinational
  // Index zero never reaches the array
  always_comb begin
    rs1_val = '0;
    rs2_val = '0;
    if (rs1_idx != 5'd0) begin
      rs1_val = regs[rs1_idx];
    end
    if (rs2_idx != 5'd0) begin
      rs2_val = regs[rs2_idx];
    end
  end

endmodule

//--- design/rv_decode.sv
// Instruction decode with immediate generation, result forwarding and operand select
`timescale 1ns/100ps

module rv_decode #(
  parameter int XLEN = 32
) (
  input  rv_ex_pkg::ex_ctl_t  id_ctl,
  input  logic [XLEN-1:0]     id_pc,
  output rv_ex_pkg::reg_idx_t rs1_idx,
  output rv_ex_pkg::reg_idx_t rs2_idx,
  input  logic [XLEN-1:0]     rs1_val,
  input  logic [XLEN-1:0]     rs2_val,
  input  rv_ex_pkg::wb_ctl_t  wb_ctl,
  input  logic [XLEN-1:0]     wb_value,
  output logic [XLEN-1:0]     opa,
  output logic [XLEN-1:0]     opb
);

  import rv_ex_pkg::*;

  logic [4:0]      opcode;
  logic [2:0]      func3;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_j;
  logic [XLEN-1:0] zimm;
  logic            fwd1;
  logic            fwd2;
  logic [XLEN-1:0] src1;
  logic [XLEN-1:0] src2;

  ////////////////////////////////////////////////////////////////////////////
  // Fields and immediates
  ////////////////////////////////////////////////////////////////////////////

  assign opcode  = id_ctl.instr[6:2];
  assign func3   = id_ctl.instr[14:12];
  assign rs1_idx = id_ctl.instr[19:15];
  assign rs2_idx = id_ctl.instr[24:20];

  // Sign extended to XLEN
  assign imm_i = XLEN'($signed(id_ctl.instr[31:20]));
  assign imm_u = XLEN'($signed({id_ctl.instr[31:12], 12'h000}));
  assign imm_j = XLEN'($signed({id_ctl.instr[31], id_ctl.instr[19:12],
                                id_ctl.instr[20], id_ctl.instr[30:21], 1'b0}));

  // CSR immediate lives in the rs1 field
  assign zimm = {{(XLEN-5){1'b0}}, id_ctl.instr[19:15]};

  ////////////////////////////////////////////////////////////////////////////
  // Forwarding from the ALU output register
  ////////////////////////////////////////////////////////////////////////////

  // Result not yet in the register file, take it from the ALU
  assign fwd1 = wb_ctl.valid && (wb_ctl.rd != 5'd0) && (wb_ctl.rd == rs1_idx);
  assign fwd2 = wb_ctl.valid && (wb_ctl.rd != 5'd0) && (wb_ctl.rd == rs2_idx);

  assign src1 = fwd1 ? wb_value : rs1_val;
  assign src2 = fwd2 ? wb_value : rs2_val;

  // Operand A
  always_comb begin
    case (opcode)
      OPC_LUI:   opa = '0;
      OPC_AUIPC: opa = id_pc;
      OPC_JAL:   opa = id_pc;
      default:   opa = src1;
    endcase
  end

  // Operand B
  // CSR register forms leave opb unused
  always_comb begin
    case (opcode)
      OPC_OP, OPC_OP32:   opb = src2;
      OPC_LUI, OPC_AUIPC: opb = imm_u;
      OPC_JAL:            opb = imm_j;
      OPC_SYSTEM:         opb = func3[2] ? zimm : imm_i;
      default:            opb = imm_i;
    endcase
  end

endmodule

//--- design/rv_alu.sv
// Integer ALU with registered result and bubble, plus combinational CSR write request
`timescale 1ns/100ps

module rv_alu #(
  parameter int XLEN = 32
) (
  input  logic                 clk,
  input  logic                 rstn,
  input  logic                 ex_stall,
  input  logic [XLEN-1:0]      id_pc,
  input  rv_ex_pkg::ex_ctl_t   id_ctl,
  input  logic [XLEN-1:0]      opa,
  input  logic [XLEN-1:0]      opb,
  output rv_ex_pkg::wb_ctl_t   wb_ctl,
  output logic [XLEN-1:0]      wb_value,
  output rv_ex_pkg::csr_addr_t csr_addr,
  output logic                 csr_we,
  output logic [XLEN-1:0]      csr_wval,
  input  logic [XLEN-1:0]      csr_rval
);

  import rv_ex_pkg::*;

  localparam int SBITS   = $clog2(XLEN);
  localparam bit IS_RV64 = (XLEN == 64);

  dec_pat_t         pat;
  logic [31:0]      opa32;
  logic [31:0]      opb32;
  logic [SBITS-1:0] shamt;
  logic [4:0]       shamt32;
  logic [XLEN-1:0]  alu_res;
  logic             alu_ok;
  logic             bubble_r;
  reg_idx_t         rd_r;

  // 32-bit result widened with its sign
  function automatic logic [XLEN-1:0] sext32(input logic [31:0] v);
    return XLEN'($signed(v));
  endfunction

  assign pat     = {id_ctl.instr[31:25], id_ctl.instr[14:12], id_ctl.instr[6:2]};
  assign opa32   = opa[31:0];
  assign opb32   = opb[31:0];
  assign shamt   = opb[SBITS-1:0];
  assign shamt32 = opb[4:0];

  ////////////////////////////////////////////////////////////////////////////
  // Result select
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    alu_ok  = 1'b1;
    alu_res = '0;
    casez (pat)
      // LUI arrives with opa at zero
      LUI, AUIPC:   alu_res = opa + opb;
      JAL, JALR:    alu_res = id_pc + XLEN'(4);
      ADDI, ADD:    alu_res = opa + opb;
      SUB:          alu_res = opa - opb;
      XORI, XOR:    alu_res = opa ^ opb;
      ORI, OR:      alu_res = opa | opb;
      ANDI, AND:    alu_res = opa & opb;
      SLLI, SLL:    alu_res = opa << shamt;
      SRLI, SRL:    alu_res = opa >> shamt;
      SRAI, SRA:    alu_res = XLEN'($signed(opa) >>> shamt);
      SLTI, SLT:    alu_res = {{(XLEN-1){1'b0}}, $signed(opa) < $signed(opb)};
      SLTIU, SLTU:  alu_res = {{(XLEN-1){1'b0}}, opa < opb};
      // Word forms exist on RV64 only
      ADDIW, ADDW: begin
        alu_res = sext32(opa32 + opb32);
        alu_ok  = IS_RV64;
      end
      SUBW: begin
        alu_res = sext32(opa32 - opb32);
        alu_ok  = IS_RV64;
      end
      SLLIW, SLLW: begin
        alu_res = sext32(opa32 << shamt32);
        alu_ok  = IS_RV64;
      end
      SRLIW, SRLW: begin
        alu_res = sext32(opa32 >> shamt32);
        alu_ok  = IS_RV64;
      end
      SRAIW, SRAW: begin
        alu_res = sext32($signed(opa32) >>> shamt32);
        alu_ok  = IS_RV64;
      end
      // CSR reads return the value before the write
      CSRRW, CSRRS, CSRRC,
      CSRRWI, CSRRSI, CSRRCI: alu_res = csr_rval;
      default:      alu_ok  = 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Output register, held while stalled
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      bubble_r <= 1'b1;
      rd_r     <= '0;
      wb_value <= '0;
    end else if (!ex_stall) begin
      // Unknown pattern turns into a bubble
      bubble_r <= id_ctl.bubble | ~alu_ok;
      rd_r     <= id_ctl.instr[11:7];
      wb_value <= alu_res;
    end
  end

  assign wb_ctl = '{valid: ~bubble_r, rd: rd_r};

  ////////////////////////////////////////////////////////////////////////////
  // CSR write request, same cycle as the instruction
  ////////////////////////////////////////////////////////////////////////////

  assign csr_addr = id_ctl.instr[31:20];

  // Set and clear only write with a non-zero source
  always_comb begin
    csr_we   = 1'b0;
    csr_wval = '0;
    if (!id_ctl.bubble) begin
      casez (pat)
        CSRRW: begin
          csr_we   = 1'b1;
          csr_wval = opa;
        end
        CSRRS: begin
          csr_we   = |opa;
          csr_wval = csr_rval | opa;
        end
        CSRRC: begin
          csr_we   = |opa;
          csr_wval = csr_rval & ~opa;
        end
        CSRRWI: begin
          csr_we   = 1'b1;
          csr_wval = opb;
        end
        CSRRSI: begin
          csr_we   = |opb;
          csr_wval = csr_rval | opb;
        end
        CSRRCI: begin
          csr_we   = |opb;
          csr_wval = csr_rval & ~opb;
        end
        default: csr_we = 1'b0;
      endcase
    end
  end

endmodule

//--- design/rv_csr_file.sv
// Machine CSR file with combinational read and stall-gated write
`timescale 1ns/100ps

module rv_csr_file #(
  parameter int XLEN = 32
) (
  input  logic                 clk,
  input  logic                 rstn,
  input  logic                 ex_stall,
  input  rv_ex_pkg::csr_addr_t csr_addr,
  input  logic                 csr_we,
  input  logic [XLEN-1:0]      csr_wval,
  output logic [XLEN-1:0]      csr_rval
);

  import rv_ex_pkg::*;

  logic [XLEN-1:0] mscratch;
  logic [XLEN-1:0] mepc;
  logic [XLEN-1:0] mcause;
  logic [XLEN-1:0] mtvec;

  // Read mux
  // unknown address gives zero
  always_comb begin
    case (csr_addr)
      CSR_MSCRATCH: csr_rval = mscratch;
      CSR_MEPC:     csr_rval = mepc;
      CSR_MCAUSE:   csr_rval = mcause;
      CSR_MTVEC:    csr_rval = mtvec;
      default:      csr_rval = '0;
    endcase
  end

  // Write on the edge that accepts the instruction
  // so the ALU still sees the old value
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      mscratch <= '0;
      mepc     <= '0;
      mcause   <= '0;
      mtvec    <= '0;
    end else if (csr_we && !ex_stall) begin
      case (csr_addr)
        CSR_MSCRATCH: mscratch <= csr_wval;
        CSR_MEPC:     mepc     <= csr_wval;
        CSR_MCAUSE:   mcause   <= csr_wval;
        CSR_MTVEC:    mtvec    <= csr_wval;
        // Writes to anything else are lost
        default: ;
      endcase
    end
  end

endmodule

//--- design/rv_ex_top.sv
// Execute stage top joining decode, register file, ALU and machine CSR file
`timescale 1ns/100ps

module rv_ex_top #(
  parameter int XLEN = 32
) (
  input  logic                 clk,
  input  logic                 rstn,
  input  logic                 ex_stall,
  input  logic [XLEN-1:0]      id_pc,
  input  rv_ex_pkg::ex_ctl_t   id_ctl,
  output rv_ex_pkg::wb_ctl_t   wb_ctl,
  output logic [XLEN-1:0]      wb_value,
  output logic                 csr_we,
  output rv_ex_pkg::csr_addr_t csr_addr,
  output logic [XLEN-1:0]      csr_wval
);

  import rv_ex_pkg::*;

  // Register file ports
  reg_idx_t        rs1_idx;
  reg_idx_t        rs2_idx;
  logic [XLEN-1:0] rs1_val;
  logic [XLEN-1:0] rs2_val;

  // Operands into the ALU
  logic [XLEN-1:0] opa;
  logic [XLEN-1:0] opb;

  // CSR read data back to the ALU
  logic [XLEN-1:0] csr_rval;

  rv_decode #(.XLEN(XLEN)) rv_decode_i (
    .id_ctl(id_ctl), .id_pc(id_pc),
    .rs1_idx(rs1_idx), .rs2_idx(rs2_idx),
    .rs1_val(rs1_val), .rs2_val(rs2_val),
    .wb_ctl(wb_ctl), .wb_value(wb_value),
    .opa(opa), .opb(opb)
  );

  rv_regfile #(.XLEN(XLEN)) rv_regfile_i (
    .clk(clk), .rstn(rstn),
    .rs1_idx(rs1_idx), .rs2_idx(rs2_idx),
    .rs1_val(rs1_val), .rs2_val(rs2_val),
    .wb_ctl(wb_ctl), .wb_value(wb_value)
  );

  rv_alu #(.XLEN(XLEN)) rv_alu_i (
    .clk(clk), .rstn(rstn), .ex_stall(ex_stall),
    .id_pc(id_pc), .id_ctl(id_ctl),
    .opa(opa), .opb(opb),
    .wb_ctl(wb_ctl), .wb_value(wb_value),
    .csr_addr(csr_addr), .csr_we(csr_we),
    .csr_wval(csr_wval), .csr_rval(csr_rval)
  );

  rv_csr_file #(.XLEN(XLEN)) rv_csr_file_i (
    .clk(clk), .rstn(rstn), .ex_stall(ex_stall),
    .csr_addr(csr_addr), .csr_we(csr_we),
    .csr_wval(csr_wval), .csr_rval(csr_rval)
  );

endmodule

//--- tests/tb_rv_ex.sv
// Directed testbench for the RV execute stage with a shadow model of registers and CSRs
`timescale 1ns/100ps

module tb_rv_ex;

  import rv_ex_pkg::*;

  localparam int XLEN            = 32;
  localparam int CLK_PERIOD      = 100;
  // Ample margin over the cycles all tests need together
  localparam int WATCHDOG_CYCLES = 2000;

  // Full 7-bit major opcodes
  localparam logic [6:0] OP_LUI   = 7'h37;
  localparam logic [6:0] OP_AUIPC = 7'h17;
  localparam logic [6:0] OP_JAL   = 7'h6f;
  localparam logic [6:0] OP_JALR  = 7'h67;
  localparam logic [6:0] OP_IMM   = 7'h13;
  localparam logic [6:0] OP_REG   = 7'h33;
  localparam logic [6:0] OP_SYS   = 7'h73;

  logic            clk;
  logic            rstn;
  logic            ex_stall;
  logic [XLEN-1:0] id_pc;
  ex_ctl_t         id_ctl;
  wb_ctl_t         wb_ctl;
  logic [XLEN-1:0] wb_value;
  logic            csr_we;
  csr_addr_t       csr_addr;
  logic [XLEN-1:0] csr_wval;

  // Shadow architectural state
  logic [31:0] sh_regs [0:31];
  logic [31:0] sh_mscratch;
  logic [31:0] sh_mepc;
  logic [31:0] sh_mcause;
  logic [31:0] sh_mtvec;

  // Expected write-back of the instruction accepted last
  logic        pend_valid;
  logic [4:0]  pend_rd;
  logic [31:0] pend_val;
  logic [31:0] cur_pc;
  logic [31:0] rng;
  int          errors;

  rv_ex_top #(.XLEN(XLEN)) rv_ex_top_i (
    .clk(clk), .rstn(rstn), .ex_stall(ex_stall),
    .id_pc(id_pc), .id_ctl(id_ctl),
    .wb_ctl(wb_ctl), .wb_value(wb_value),
    .csr_we(csr_we), .csr_addr(csr_addr), .csr_wval(csr_wval)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // Instruction encoders and random source
  ////////////////////////////////////////////////////////////////////////////

  function automatic instr_t enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                   input logic [4:0] rs1, input logic [2:0] f3,
                                   input logic [4:0] rd, input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic instr_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                   input logic [2:0] f3, input logic [4:0] rd,
                                   input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic instr_t enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                   input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic next_rand(output logic [31:0] v);
    rng = xorshift(rng);
    v   = rng;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] csr_read(input logic [11:0] addr);
    case (addr)
      12'h340: return sh_mscratch;
      12'h341: return sh_mepc;
      12'h342: return sh_mcause;
      12'h305: return sh_mtvec;
      default: return 32'h0;
    endcase
  endfunction

  task automatic csr_write(input logic [11:0] addr, input logic [31:0] v);
    case (addr)
      12'h340: sh_mscratch = v;
      12'h341: sh_mepc     = v;
      12'h342: sh_mcause   = v;
      12'h305: sh_mtvec    = v;
      default: ;
    endcase
  endtask

  // Program order update of the shadow state
  task automatic model_step(input instr_t ins, output logic [31:0] res,
                            output logic we, output logic [31:0] wval);
    logic [6:0]  opc;
    logic [2:0]  f3;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] old;
    logic [31:0] src;
    opc  = ins[6:0];
    f3   = ins[14:12];
    a    = sh_regs[ins[19:15]];
    b    = (opc == OP_IMM) ? {{20{ins[31]}}, ins[31:20]} : sh_regs[ins[24:20]];
    res  = 32'h0;
    we   = 1'b0;
    wval = 32'h0;
    case (opc)
      OP_LUI:          res = {ins[31:12], 12'h000};
      OP_AUIPC:        res = cur_pc + {ins[31:12], 12'h000};
      OP_JAL, OP_JALR: res = cur_pc + 32'd4;
      OP_IMM, OP_REG: begin
        case (f3)
          3'd0:    res = (opc == OP_REG && ins[30]) ? a - b : a + b;
          3'd1:    res = a << b[4:0];
          3'd2:    res = {31'h0, $signed(a) < $signed(b)};
          3'd3:    res = {31'h0, a < b};
          3'd4:    res = a ^ b;
          3'd5: begin
            if (ins[30]) begin
              res = $signed(a) >>> b[4:0];
            end else begin
              res = a >> b[4:0];
            end
          end
          3'd6:    res = a | b;
          default: res = a & b;
        endcase
      end
      default: begin
        // SYSTEM with funct3 bit 2 selecting the zimm source
        old = csr_read(ins[31:20]);
        src = ins[14] ? {27'h0, ins[19:15]} : a;
        res = old;
        case (f3[1:0])
          2'd1: begin
            we   = 1'b1;
            wval = src;
          end
          2'd2: begin
            we   = |src;
            wval = old | src;
          end
          default: begin
            we   = |src;
            wval = old & ~src;
          end
        endcase
        if (we) begin
          csr_write(ins[31:20], wval);
        end
      end
    endcase
    if (ins[11:7] != 5'd0) begin
      sh_regs[ins[11:7]] = res;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Checks and drivers
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_result();
    assert (wb_ctl.valid == pend_valid) else begin
      errors++;
      $display("[FAIL] %0t: wb_ctl.valid is %b, expected %b",
               $time, wb_ctl.valid, pend_valid);
    end
    if (pend_valid) begin
      assert (wb_ctl.rd == pend_rd) else begin
        errors++;
        $display("[FAIL] %0t: wb_ctl.rd is %0d, expected %0d", $time, wb_ctl.rd, pend_rd);
      end
      assert (wb_value == pend_val) else begin
        errors++;
        $display("[FAIL] %0t: wb_value is %h, expected %h", $time, wb_value, pend_val);
      end
    end
  endtask

  task automatic check_csr(input logic we, input logic [11:0] addr,
                           input logic [31:0] wval);
    assert (csr_we == we) else begin
      errors++;
      $display("[FAIL] %0t: csr_we is %b, expected %b", $time, csr_we, we);
    end
    if (we) begin
      assert (csr_addr == addr && csr_wval == wval) else begin
        errors++;
        $display("[FAIL] %0t: CSR write %h <= %h, expected %h <= %h",
                 $time, csr_addr, csr_wval, addr, wval);
      end
    end
  endtask

  // Called at a rising edge, returns at the edge that accepts the instruction
  // The result is checked by the following call
  task automatic issue_instr(input instr_t ins, input logic bub);
    logic [31:0] res;
    logic        we;
    logic [31:0] wval;
    res  = 32'h0;
    we   = 1'b0;
    wval = 32'h0;
    if (!bub) begin
      model_step(ins, res, we, wval);
    end
    id_ctl.bubble <= bub;
    id_ctl.instr  <= ins;
    id_pc         <= cur_pc;
    @(negedge clk);
    check_result();
    check_csr(we, ins[31:20], wval);
    @(posedge clk);
    pend_valid = !bub;
    pend_rd    = ins[11:7];
    pend_val   = res;
  endtask

  // LUI then a dependent ADDI
  task automatic load_reg(input logic [4:0] rd, input logic [31:0] v);
    logic [19:0] hi;
    hi = v[31:12] + {19'h0, v[11]};
    issue_instr(enc_u(hi, rd, OP_LUI), 1'b0);
    issue_instr(enc_i(v[11:0], rd, 3'd0, rd, OP_IMM), 1'b0);
  endtask

  // Next instruction waits three stalled edges with inputs held
  task automatic stall_hold(input instr_t ins);
    logic [31:0] res;
    logic        we;
    logic [31:0] wval;
    model_step(ins, res, we, wval);
    id_ctl.bubble <= 1'b0;
    id_ctl.instr  <= ins;
    id_pc         <= cur_pc;
    ex_stall      <= 1'b1;
    for (int n = 0; n < 4; n++) begin
      @(negedge clk);
      check_result();
      check_csr(we, ins[31:20], wval);
      @(posedge clk);
      if (n == 2) begin
        ex_stall <= 1'b0;
      end
    end
    pend_valid = 1'b1;
    pend_rd    = ins[11:7];
    pend_val   = res;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic test_reset();
    @(negedge clk);
    assert (!wb_ctl.valid && !csr_we) else begin
      errors++;
      $display("[FAIL] %0t: valid %b or csr_we %b high after reset",
               $time, wb_ctl.valid, csr_we);
    end
    @(posedge clk);
    // CSRRS x1, mscratch, x0
    issue_instr(enc_i(12'h340, 5'd0, 3'd2, 5'd1, OP_SYS), 1'b0);
  endtask

  // Each operation reads the rd of the one before
  task automatic test_arith();
    logic [31:0] r;
    logic [4:0]  prev;
    logic [4:0]  rd;
    next_rand(r);
    load_reg(5'd10, r);
    next_rand(r);
    load_reg(5'd11, r);
    prev = 5'd10;
    for (int i = 0; i < 16; i++) begin
      next_rand(r);
      rd = 5'd12 + 5'(i % 4);
      case (r[2:0])
        3'd0:    issue_instr(enc_i(r[31:20], prev, 3'd0, rd, OP_IMM), 1'b0);
        3'd1:    issue_instr(enc_u(r[31:12], rd, OP_LUI), 1'b0);
        3'd2:    issue_instr(enc_r(7'h00, 5'd11, prev, 3'd0, rd, OP_REG), 1'b0);
        3'd3:    issue_instr(enc_r(7'h20, 5'd11, prev, 3'd0, rd, OP_REG), 1'b0);
        3'd4:    issue_instr(enc_r(7'h00, 5'd11, prev, 3'd4, rd, OP_REG), 1'b0);
        3'd5:    issue_instr(enc_r(7'h00, 5'd11, prev, 3'd6, rd, OP_REG), 1'b0);
        default: issue_instr(enc_r(7'h00, 5'd11, prev, 3'd7, rd, OP_REG), 1'b0);
      endcase
      prev = rd;
    end
  endtask

  task automatic test_shift_cmp();
    logic [31:0] r;
    logic [4:0]  amt;
    // Negative source so SRA and SRL differ
    next_rand(r);
    load_reg(5'd10, r | 32'h8000_0000);
    for (int k = 0; k < 4; k++) begin
      next_rand(r);
      case (k)
        0:       amt = 5'd0;
        1:       amt = 5'd1;
        2:       amt = 5'd31;
        default: amt = r[4:0];
      endcase
      issue_instr(enc_i({7'h00, amt}, 5'd0, 3'd0, 5'd11, OP_IMM), 1'b0);
      issue_instr(enc_r(7'h00, 5'd11, 5'd10, 3'd1, 5'd12, OP_REG), 1'b0);
      issue_instr(enc_r(7'h00, 5'd11, 5'd10, 3'd5, 5'd13, OP_REG), 1'b0);
      issue_instr(enc_r(7'h20, 5'd11, 5'd10, 3'd5, 5'd14, OP_REG), 1'b0);
      issue_instr(enc_i({7'h00, amt}, 5'd10, 3'd1, 5'd15, OP_IMM), 1'b0);
      issue_instr(enc_i({7'h00, amt}, 5'd10, 3'd5, 5'd16, OP_IMM), 1'b0);
      issue_instr(enc_i({7'h20, amt}, 5'd10, 3'd5, 5'd17, OP_IMM), 1'b0);
    end
    // Positive against negative operand
    next_rand(r);
    load_reg(5'd20, r & 32'h7fff_ffff);
    next_rand(r);
    load_reg(5'd21, r | 32'h8000_0000);
    issue_instr(enc_r(7'h00, 5'd21, 5'd20, 3'd2, 5'd22, OP_REG), 1'b0);
    issue_instr(enc_r(7'h00, 5'd20, 5'd21, 3'd2, 5'd22, OP_REG), 1'b0);
    issue_instr(enc_r(7'h00, 5'd21, 5'd20, 3'd3, 5'd23, OP_REG), 1'b0);
    issue_instr(enc_r(7'h00, 5'd20, 5'd21, 3'd3, 5'd23, OP_REG), 1'b0);
    issue_instr(enc_i(12'h800, 5'd20, 3'd2, 5'd24, OP_IMM), 1'b0);
    issue_instr(enc_i(12'hfff, 5'd20, 3'd3, 5'd24, OP_IMM), 1'b0);
  endtask

  task automatic test_pc_ops();
    logic [31:0] r;
    next_rand(r);
    cur_pc = {r[31:2], 2'b00};
    next_rand(r);
    issue_instr(enc_u(r[31:12], 5'd25, OP_AUIPC), 1'b0);
    issue_instr(enc_u(r[31:12], 5'd26, OP_JAL), 1'b0);
    issue_instr(enc_i(12'h010, 5'd10, 3'd0, 5'd27, OP_JALR), 1'b0);
    cur_pc = 32'h0;
  endtask

  task automatic test_csr();
    // mscratch by register source
    issue_instr(enc_i(12'h340, 5'd10, 3'd1, 5'd1, OP_SYS), 1'b0);
    issue_instr(enc_i(12'h340, 5'd11, 3'd2, 5'd2, OP_SYS), 1'b0);
    issue_instr(enc_i(12'h340, 5'd20, 3'd3, 5'd3, OP_SYS), 1'b0);
    // x0 source leaves the CSR alone
    issue_instr(enc_i(12'h340, 5'd0, 3'd2, 5'd4, OP_SYS), 1'b0);
    issue_instr(enc_i(12'h340, 5'd0, 3'd3, 5'd4, OP_SYS), 1'b0);
    // mtvec by zimm
    issue_instr(enc_i(12'h305, 5'h15, 3'd5, 5'd5, OP_SYS), 1'b0);
    issue_instr(enc_i(12'h305, 5'h0a, 3'd6, 5'd5, OP_SYS), 1'b0);
    issue_instr(enc_i(12'h305, 5'h01, 3'd7, 5'd5, OP_SYS), 1'b0);
    issue_instr(enc_i(12'h305, 5'h00, 3'd6, 5'd6, OP_SYS), 1'b0);
    issue_instr(enc_i(12'h305, 5'd0, 3'd2, 5'd6, OP_SYS), 1'b0);
    // Unknown address
    issue_instr(enc_i(12'h7c0, 5'd10, 3'd1, 5'd7, OP_SYS), 1'b0);
    issue_instr(enc_i(12'h7c0, 5'd0, 3'd2, 5'd7, OP_SYS), 1'b0);
  endtask

  task automatic test_stall_bubble();
    issue_instr(enc_i(12'h340, 5'h03, 3'd5, 5'd8, OP_SYS), 1'b0);
    // A set during the stall would show in the captured old value
    stall_hold(enc_i(12'h340, 5'h0c, 3'd6, 5'd9, OP_SYS));
    // Bubble carrying a CSR write
    issue_instr(enc_i(12'h340, 5'd10, 3'd1, 5'd9, OP_SYS), 1'b1);
    issue_instr(enc_i(12'h340, 5'd0, 3'd2, 5'd9, OP_SYS), 1'b0);
    issue_instr(32'h0, 1'b1);
    issue_instr(32'h0, 1'b1);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    for (int i = 0; i < 32; i++) begin
      sh_regs[i] = 32'h0;
    end
    sh_mscratch = 32'h0;
    sh_mepc     = 32'h0;
    sh_mcause   = 32'h0;
    sh_mtvec    = 32'h0;
    pend_valid  = 1'b0;
    pend_rd     = 5'd0;
    pend_val    = 32'h0;
    cur_pc      = 32'h0;
    rng         = 32'h30f170c2;
    errors      = 0;
    rstn          <= 1'b0;
    ex_stall      <= 1'b0;
    id_pc         <= '0;
    id_ctl.bubble <= 1'b1;
    id_ctl.instr  <= 32'h0;
    repeat (2) @(posedge clk);
    rstn <= 1'b1;
    test_reset();
    test_arith();
    test_shift_cmp();
    test_pc_ops();
    test_csr();
    test_stall_bubble();
    $display("Run complete with %0d errors", errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles with %0d errors", WATCHDOG_CYCLES, errors);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

//--- tb.f
design/rv_ex_pkg.sv
design/rv_regfile.sv
design/rv_decode.sv
design/rv_alu.sv
design/rv_csr_file.sv
design/rv_ex_top.sv
tests/tb_rv_ex.sv

//--- run.sh
#!/bin/sh
# Verilator build and run of the execute stage testbench
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_rv_ex -f tb.f
./obj_dir/Vtb_rv_ex | tee sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi
grep -q "TESTBENCH PASSED" sim.log
